// File: Makefile
TOP := nbody_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

// File: hw/body_mem.sv
/*
 * Per-body store of an x/y pair, separate x and y write enables,
 * one write port and one registered read port
 */
module body_mem
    import nbody_pkg::*;
#(
    parameter int BODIES = 512,
    localparam int IDX_W = $clog2(BODIES)
) (
    input  logic             clk,
    input  mem_wr_t          wr_i,
    input  logic [IDX_W-1:0] rd_addr_i,
    output body_vec_t        rd_o
);

    logic [DATA_WIDTH-1:0] mem_x [BODIES];
    logic [DATA_WIDTH-1:0] mem_y [BODIES];
    logic [IDX_W-1:0]      wr_addr;

    // Only the low index bits are meaningful for this depth
    assign wr_addr = wr_i.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (wr_i.en_x) begin
            mem_x[wr_addr] <= wr_i.data.x;
        end
        if (wr_i.en_y) begin
            mem_y[wr_addr] <= wr_i.data.y;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_o.x <= mem_x[rd_addr_i];
        rd_o.y <= mem_y[rd_addr_i];
    end

endmodule

// File: hw/nbody_pkg.sv
/*
 * Shared definitions of the n-body stepping engine:
 * bus and data widths, address fields, sequencer states and bus/memory structs
 */
package nbody_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int EXT_DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;
    localparam int FIELD_WIDTH = 7;
    // Lower address bits select the body, also the widest body index
    localparam int BODY_FIELD_WIDTH = ADDR_WIDTH - FIELD_WIDTH;

    // Used for positions and for velocities
    typedef struct packed {
        logic [DATA_WIDTH-1:0] x;
        logic [DATA_WIDTH-1:0] y;
    } body_vec_t;

    typedef struct packed {
        logic                      write;
        logic                      read;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [EXT_DATA_WIDTH-1:0] writedata;
    } bus_req_t;

    typedef struct packed {
        logic                        en_x;
        logic                        en_y;
        logic [BODY_FIELD_WIDTH-1:0] addr;
        body_vec_t                   data;
    } mem_wr_t;

    // Upper 7 address bits
    typedef enum logic [FIELD_WIDTH-1:0] {
        GO       = 7'h40,
        READ     = 7'h41,
        N_BODIES = 7'h42,
        GAP      = 7'h43,
        X_LO     = 7'h44,
        X_HI     = 7'h45,
        Y_LO     = 7'h46,
        Y_HI     = 7'h47,
        VX_LO    = 7'h4a,
        VX_HI    = 7'h4b,
        VY_LO    = 7'h4c,
        VY_HI    = 7'h4d,
        DONE     = 7'h50,
        RD_X_LO  = 7'h51,
        RD_X_HI  = 7'h52,
        RD_Y_LO  = 7'h53,
        RD_Y_HI  = 7'h54
    } reg_field_e;

    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        DRAIN
    } seq_state_e;

endpackage

// File: hw/nbody_regs.sv
/*
 * Bus register block: decodes the address field, holds the run controls,
 * stages the lower half of 64-bit loads and muxes the read-back data
 */
module nbody_regs
    import nbody_pkg::*;
#(
    parameter int BODIES = 512,
    localparam int IDX_W = $clog2(BODIES),
    localparam int CNT_W = $clog2(BODIES + 1)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  bus_req_t                  bus_i,
    input  logic                      chipselect_i,
    input  seq_state_e                seq_state_i,
    input  logic                      done_i,
    input  body_vec_t                 pos_rd_i,
    output logic                      go_o,
    output logic                      read_sw_o,
    output logic [CNT_W-1:0]          n_bodies_o,
    output logic [EXT_DATA_WIDTH-1:0] gap_o,
    output mem_wr_t                   pos_wr_o,
    output mem_wr_t                   vel_wr_o,
    output logic [IDX_W-1:0]          rd_body_o,
    output logic [EXT_DATA_WIDTH-1:0] readdata_o
);

    reg_field_e                field;
    reg_field_e                rd_field;
    logic                      wr_stb;
    logic                      rd_stb;
    logic                      idle;
    logic                      rd_pend;
    logic [EXT_DATA_WIDTH-1:0] lo_q;
    logic [DATA_WIDTH-1:0]     commit_data;

    assign field = reg_field_e'(bus_i.addr[ADDR_WIDTH-1 -: FIELD_WIDTH]);
    assign wr_stb = bus_i.write & chipselect_i;
    assign rd_stb = bus_i.read & chipselect_i;
    assign idle = (seq_state_i == IDLE);
    assign rd_body_o = bus_i.addr[IDX_W-1:0];
    assign commit_data = {bus_i.writedata, lo_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_o <= 1'b0;
            read_sw_o <= 1'b0;
            n_bodies_o <= '0;
            gap_o <= '0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_stb;
            if (wr_stb) begin
                case (field)
                    GO:       go_o <= bus_i.writedata[0];
                    READ:     read_sw_o <= bus_i.writedata[0];
                    N_BODIES: n_bodies_o <= bus_i.writedata[CNT_W-1:0];
                    GAP:      gap_o <= bus_i.writedata;
                    default:  ;
                endcase
            end
        end
    end

    // Low halves wait here for the matching high-half write
    always_ff @(posedge clk) begin
        if (wr_stb && (field inside {X_LO, Y_LO, VX_LO, VY_LO})) begin
            lo_q <= bus_i.writedata;
        end
        if (rd_stb) begin
            rd_field <= field;
        end
    end

    // Loads only land while the sequencer is idle
    always_comb begin
        pos_wr_o.en_x = wr_stb && idle && (field == X_HI);
        pos_wr_o.en_y = wr_stb && idle && (field == Y_HI);
        pos_wr_o.addr = bus_i.addr[BODY_FIELD_WIDTH-1:0];
        pos_wr_o.data.x = commit_data;
        pos_wr_o.data.y = commit_data;
        vel_wr_o.en_x = wr_stb && idle && (field == VX_HI);
        vel_wr_o.en_y = wr_stb && idle && (field == VY_HI);
        vel_wr_o.addr = bus_i.addr[BODY_FIELD_WIDTH-1:0];
        vel_wr_o.data.x = commit_data;
        vel_wr_o.data.y = commit_data;
    end

    // Memory output arrives one cycle after the strobe
    always_comb begin
        if (!rd_pend) begin
            readdata_o = '0;
        end else begin
            case (rd_field)
                DONE:    readdata_o = {{(EXT_DATA_WIDTH-1){1'b0}}, done_i};
                RD_X_LO: readdata_o = pos_rd_i.x[EXT_DATA_WIDTH-1:0];
                RD_X_HI: readdata_o = pos_rd_i.x[DATA_WIDTH-1:EXT_DATA_WIDTH];
                RD_Y_LO: readdata_o = pos_rd_i.y[EXT_DATA_WIDTH-1:0];
                RD_Y_HI: readdata_o = pos_rd_i.y[DATA_WIDTH-1:EXT_DATA_WIDTH];
                default: readdata_o = '1;
            endcase
        end
    end

endmodule

// File: hw/nbody_top.sv
/*
 * N-body stepping engine top: register block, sequencer, position and
 * velocity memories and the position adder on a memory-mapped bus
 */
module nbody_top
    import nbody_pkg::*;
#(
    parameter int BODIES = 512,
    parameter int ADD_LAT = 4,
    localparam int IDX_W = $clog2(BODIES),
    localparam int CNT_W = $clog2(BODIES + 1)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  bus_req_t                  bus_i,
    input  logic                      chipselect_i,
    output logic [EXT_DATA_WIDTH-1:0] readdata_o
);

    logic                      go;
    logic                      read_sw;
    logic                      done;
    logic                      sweep_valid;
    logic [CNT_W-1:0]          n_bodies;
    logic [EXT_DATA_WIDTH-1:0] gap;
    logic [IDX_W-1:0]          rd_body;
    logic [IDX_W-1:0]          rd_idx;
    logic [IDX_W-1:0]          mem_rd_addr;
    seq_state_e                state;
    mem_wr_t                   bus_pos_wr;
    mem_wr_t                   vel_wr;
    mem_wr_t                   add_wr;
    mem_wr_t                   pos_wr;
    body_vec_t                 pos_rd;
    body_vec_t                 vel_rd;

    // Bus owns the memories in IDLE, the sweep otherwise
    assign mem_rd_addr = (state == IDLE) ? rd_body : rd_idx;
    assign pos_wr = (state == IDLE) ? bus_pos_wr : add_wr;

    nbody_regs #(.BODIES(BODIES)) regs0 (
        .clk(clk), .rst(rst), .bus_i(bus_i), .chipselect_i(chipselect_i),
        .seq_state_i(state), .done_i(done), .pos_rd_i(pos_rd),
        .go_o(go), .read_sw_o(read_sw), .n_bodies_o(n_bodies), .gap_o(gap),
        .pos_wr_o(bus_pos_wr), .vel_wr_o(vel_wr), .rd_body_o(rd_body),
        .readdata_o(readdata_o)
    );

    step_sequencer #(.BODIES(BODIES), .ADD_LAT(ADD_LAT)) seq0 (
        .clk(clk), .rst(rst), .go_i(go), .read_sw_i(read_sw),
        .n_bodies_i(n_bodies), .gap_i(gap), .state_o(state), .done_o(done),
        .rd_idx_o(rd_idx), .sweep_valid_o(sweep_valid)
    );

    body_mem #(.BODIES(BODIES)) pos_mem (
        .clk(clk), .wr_i(pos_wr), .rd_addr_i(mem_rd_addr), .rd_o(pos_rd)
    );

    body_mem #(.BODIES(BODIES)) vel_mem (
        .clk(clk), .wr_i(vel_wr), .rd_addr_i(mem_rd_addr), .rd_o(vel_rd)
    );

    pos_adder #(.BODIES(BODIES), .ADD_LAT(ADD_LAT)) add0 (
        .clk(clk), .rst(rst), .valid_i(sweep_valid), .idx_i(rd_idx),
        .pos_i(pos_rd), .vel_i(vel_rd), .wr_o(add_wr)
    );

endmodule

// File: hw/pos_adder.sv
/*
 * Pipelined position adder: x + vx and y + vy over ADD_LAT stages,
 * with the valid bit and body index carried alongside each sum
 */
module pos_adder
    import nbody_pkg::*;
#(
    parameter int BODIES = 512,
    parameter int ADD_LAT = 4,
    localparam int IDX_W = $clog2(BODIES)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    input  logic [IDX_W-1:0] idx_i,
    input  body_vec_t        pos_i,
    input  body_vec_t        vel_i,
    output mem_wr_t          wr_o
);

    logic               valid_d;
    logic [IDX_W-1:0]   idx_d;
    logic [ADD_LAT-1:0] stg_valid;
    logic [IDX_W-1:0]   stg_idx [ADD_LAT];
    body_vec_t          stg_sum [ADD_LAT];

    // Valid and index wait one cycle for the registered memory read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_d <= 1'b0;
            stg_valid <= '0;
        end else begin
            valid_d <= valid_i;
            stg_valid[0] <= valid_d;
            for (int i = 1; i < ADD_LAT; i++) begin
                stg_valid[i] <= stg_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_d <= idx_i;
        stg_idx[0] <= idx_d;
        stg_sum[0].x <= pos_i.x + vel_i.x;
        stg_sum[0].y <= pos_i.y + vel_i.y;
        for (int i = 1; i < ADD_LAT; i++) begin
            stg_idx[i] <= stg_idx[i-1];
            stg_sum[i] <= stg_sum[i-1];
        end
    end

    // Both components land together
    always_comb begin
        wr_o.en_x = stg_valid[ADD_LAT-1];
        wr_o.en_y = stg_valid[ADD_LAT-1];
        wr_o.addr = BODY_FIELD_WIDTH'(stg_idx[ADD_LAT-1]);
        wr_o.data = stg_sum[ADD_LAT-1];
    end

endmodule

// File: hw/step_sequencer.sv
/*
 * Run sequencer: sweeps the bodies once per step, waits for the adder
 * pipeline to drain, counts steps and drives the GO/READ/DONE handshake
 */
module step_sequencer
    import nbody_pkg::*;
#(
    parameter int BODIES = 512,
    parameter int ADD_LAT = 4,
    localparam int IDX_W = $clog2(BODIES),
    localparam int CNT_W = $clog2(BODIES + 1),
    localparam int DRAIN_W = $clog2(ADD_LAT + 2)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go_i,
    input  logic                      read_sw_i,
    input  logic [CNT_W-1:0]          n_bodies_i,
    input  logic [EXT_DATA_WIDTH-1:0] gap_i,
    output seq_state_e                state_o,
    output logic                      done_o,
    output logic [IDX_W-1:0]          rd_idx_o,
    output logic                      sweep_valid_o
);

    // Last read needs one memory cycle plus ADD_LAT adder cycles to land
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(ADD_LAT + 1);

    logic [DRAIN_W-1:0]        drain_cnt;
    logic [EXT_DATA_WIDTH-1:0] step_cnt;
    logic                      last_idx;
    logic                      last_step;
    seq_state_e                step_entry;

    assign sweep_valid_o = (state_o == SWEEP);
    assign last_idx = (CNT_W'(rd_idx_o) + CNT_W'(1)) >= n_bodies_i;
    // GAP of zero still runs one step
    assign last_step = ({1'b0, step_cnt} + (EXT_DATA_WIDTH + 1)'(1)) >= {1'b0, gap_i};
    // No bodies, nothing to sweep
    assign step_entry = (n_bodies_i == '0) ? DRAIN : SWEEP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_o <= IDLE;
            done_o <= 1'b0;
            rd_idx_o <= '0;
            drain_cnt <= '0;
            step_cnt <= '0;
        end else begin
            case (state_o)
                IDLE: begin
                    if (read_sw_i) begin
                        done_o <= 1'b0;
                    end else if (go_i && !done_o) begin
                        state_o <= step_entry;
                        rd_idx_o <= '0;
                        drain_cnt <= '0;
                        step_cnt <= '0;
                    end
                end
                SWEEP: begin
                    if (!go_i) begin
                        state_o <= IDLE;
                    end else if (last_idx) begin
                        state_o <= DRAIN;
                        drain_cnt <= '0;
                    end else begin
                        rd_idx_o <= rd_idx_o + 1'b1;
                    end
                end
                DRAIN: begin
                    if (!go_i) begin
                        state_o <= IDLE;
                    end else if (drain_cnt != DRAIN_LAST) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end else if (last_step) begin
                        state_o <= IDLE;
                        done_o <= 1'b1;
                    end else begin
                        state_o <= step_entry;
                        step_cnt <= step_cnt + 1'b1;
                        rd_idx_o <= '0;
                        drain_cnt <= '0;
                    end
                end
                default: state_o <= IDLE;
            endcase
        end
    end

endmodule

// File: tb.f
hw/nbody_pkg.sv
hw/body_mem.sv
hw/pos_adder.sv
hw/step_sequencer.sv
hw/nbody_regs.sv
hw/nbody_top.sv
verification/nbody_checker.sv
verification/nbody_tb.sv

// File: verification/nbody_checker.sv
/*
 * Concurrent assertions on the run sequencer: DONE timing, sweep index
 * range and the run start condition
 */
module nbody_checker
    import nbody_pkg::*;
#(
    parameter int IDX_W = 4,
    parameter int CNT_W = 5
) (
    input logic             clk,
    input logic             rst,
    input logic             go_i,
    input logic             read_sw_i,
    input logic             done_i,
    input seq_state_e       state_i,
    input logic [IDX_W-1:0] rd_idx_i,
    input logic [CNT_W-1:0] n_bodies_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // DONE only rises together with the return to IDLE
    done_on_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(done_i) |-> (state_i == IDLE) && ($past(state_i) != IDLE))
        else $error("done rose outside entry to IDLE");

    idx_in_range: assert property (@(posedge clk) disable iff (rst)
        (state_i == SWEEP) |-> (CNT_W'(rd_idx_i) < n_bodies_i))
        else $error("sweep index beyond body count");

    // A run starts only on GO high, READ low and DONE low
    start_cond: assert property (@(posedge clk) disable iff (rst)
        (state_i == IDLE) && !(go_i && !read_sw_i && !done_i) |=> (state_i == IDLE))
        else $error("sequencer left IDLE without a valid start");

endmodule

bind step_sequencer nbody_checker #(.IDX_W(IDX_W), .CNT_W(CNT_W)) chk0 (
    .clk(clk), .rst(rst), .go_i(go_i), .read_sw_i(read_sw_i), .done_i(done_o),
    .state_i(state_o), .rd_idx_i(rd_idx_o), .n_bodies_i(n_bodies_i)
);

// File: verification/nbody_patterns.txt
// Word 0 is the body count, word 1 is GAP
// Then one line per body with x, y, vx and vy as 64-bit hex
0000000000000010
0000000000000005
0000000000000000 0000000000000000 0000000000000001 0000000000000002
0000000100000002 0000000300000004 fffffffffffffffd 0000000000000007
7ffffffffffffffe 8000000000000001 0000000000000001 ffffffffffffffff
fffffffffffffff0 0000000000000010 0000000000000003 fffffffffffffffc
123456789abcdef0 0fedcba987654321 0000000100000000 ffffffff00000000
00000000ffffffff ffffffff00000000 0000000000000001 0000000000000001
8000000000000000 7fffffffffffffff ffffffffffffffff 0000000000000001
deadbeefcafef00d 0123456789abcdef 0000000000001000 fffffffffffff000
0000000000000064 ffffffffffffff9c 000000000000000a fffffffffffffff6
00000000fffffffe 0000000100000001 0000000000000002 fffffffffffffffe
a5a5a5a55a5a5a5a 5a5a5a5aa5a5a5a5 0000000011111111 ffffffffeeeeeeef
0000000000000000 ffffffffffffffff 7fffffffffffffff 8000000000000001
1111111122222222 3333333344444444 0000000000000000 0000000000000000
fffffffffffffffb 0000000000000005 0000000000000001 ffffffffffffffff
0000123400005678 00009abc0000def0 ffffffffffff0000 0000000000010000
3fffffffffffffff c000000000000000 4000000000000000 4000000000000000

// File: verification/nbody_tb.sv
/*
 * Testbench of the n-body stepping engine: loads bodies from the pattern
 * file, runs the engine over the bus and checks positions against a model
 */
module nbody_tb
    import nbody_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BODIES = 16;
    localparam int ADD_LAT = 4;
    localparam int NWORDS = 2 + 4 * BODIES;
    localparam int POLL_LIMIT = 400;

    logic                      clk;
    logic                      rst;
    bus_req_t                  bus;
    logic                      chipselect;
    logic [EXT_DATA_WIDTH-1:0] readdata;

    logic [DATA_WIDTH-1:0] pat [NWORDS];
    logic [DATA_WIDTH-1:0] x0 [BODIES];
    logic [DATA_WIDTH-1:0] y0 [BODIES];
    logic [DATA_WIDTH-1:0] vx [BODIES];
    logic [DATA_WIDTH-1:0] vy [BODIES];
    logic [DATA_WIDTH-1:0] steps [BODIES];
    logic [DATA_WIDTH-1:0] gap_eff;
    logic [31:0]           lfsr_q;
    int                    n_bodies;
    int                    value_errs;
    int                    other_errs;

    nbody_top #(.BODIES(BODIES), .ADD_LAT(ADD_LAT)) dut0 (
        .clk(clk), .rst(rst), .bus_i(bus), .chipselect_i(chipselect),
        .readdata_o(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int nbits);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(lfsr_q[31]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // Enough DONE polls to outlast one whole run at two cycles per poll
    function automatic int run_window_reads();
        return int'(gap_eff) * (n_bodies + ADD_LAT + 2) / 2 + 4;
    endfunction

    task automatic idle_gap();
        int cycles;
        cycles = take_bits(2);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic bus_write(input logic [FIELD_WIDTH-1:0] field, input int body,
                             input logic [EXT_DATA_WIDTH-1:0] data);
        @(posedge clk);
        bus.write <= 1'b1;
        bus.addr <= {field, BODY_FIELD_WIDTH'(body)};
        bus.writedata <= data;
        chipselect <= 1'b1;
        @(posedge clk);
        bus.write <= 1'b0;
        chipselect <= 1'b0;
        idle_gap();
    endtask

    // Data is valid in the cycle after the strobe
    task automatic bus_read(input logic [FIELD_WIDTH-1:0] field, input int body,
                            output logic [EXT_DATA_WIDTH-1:0] data);
        @(posedge clk);
        bus.read <= 1'b1;
        bus.addr <= {field, BODY_FIELD_WIDTH'(body)};
        chipselect <= 1'b1;
        // No read pending yet so the bus returns zero
        @(negedge clk);
        check_value("idle readdata", '0, readdata);
        @(posedge clk);
        bus.read <= 1'b0;
        chipselect <= 1'b0;
        @(negedge clk);
        data = readdata;
        idle_gap();
    endtask

    task automatic write_word(input logic [FIELD_WIDTH-1:0] lo, input logic [FIELD_WIDTH-1:0] hi,
                              input int body, input logic [DATA_WIDTH-1:0] v);
        bus_write(lo, body, v[31:0]);
        bus_write(hi, body, v[63:32]);
    endtask

    task automatic read_word(input logic [FIELD_WIDTH-1:0] lo, input logic [FIELD_WIDTH-1:0] hi,
                             input int body, output logic [DATA_WIDTH-1:0] v);
        logic [EXT_DATA_WIDTH-1:0] lo_d;
        logic [EXT_DATA_WIDTH-1:0] hi_d;
        bus_read(lo, body, lo_d);
        bus_read(hi, body, hi_d);
        v = {hi_d, lo_d};
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_bodies();
        for (int i = 0; i < n_bodies; i++) begin
            write_word(X_LO, X_HI, i, x0[i]);
            write_word(Y_LO, Y_HI, i, y0[i]);
            write_word(VX_LO, VX_HI, i, vx[i]);
            write_word(VY_LO, VY_HI, i, vy[i]);
        end
    endtask

    // Expected position is start plus velocity times steps taken, mod 2^64
    task automatic check_positions(input string name);
        logic [DATA_WIDTH-1:0] x;
        logic [DATA_WIDTH-1:0] y;
        for (int i = 0; i < n_bodies; i++) begin
            read_word(RD_X_LO, RD_X_HI, i, x);
            read_word(RD_Y_LO, RD_Y_HI, i, y);
            check_value($sformatf("%s x[%0d]", name, i), x0[i] + steps[i] * vx[i], x);
            check_value($sformatf("%s y[%0d]", name, i), y0[i] + steps[i] * vy[i], y);
        end
    endtask

    task automatic advance(input int count);
        for (int i = 0; i < count; i++) begin
            steps[i] = steps[i] + gap_eff;
        end
    endtask

    task automatic wait_done(input string name);
        logic [EXT_DATA_WIDTH-1:0] d;
        int polls;
        d = '0;
        polls = 0;
        while (d[0] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_read(DONE, 0, d);
            polls++;
        end
        assert (d[0] === 1'b1) else begin
            other_errs++;
            $display("Timeout in %s: DONE did not rise within %0d polls", name, POLL_LIMIT);
        end
    endtask

    task automatic expect_done_low(input string name, input int reads);
        logic [EXT_DATA_WIDTH-1:0] d;
        for (int i = 0; i < reads; i++) begin
            bus_read(DONE, 0, d);
            check_value(name, '0, d);
        end
    endtask

    initial begin
        logic [EXT_DATA_WIDTH-1:0] d;
        int n_part;
        rst = 1'b1;
        bus = '0;
        chipselect = 1'b0;
        lfsr_q = 32'h6be9;
        value_errs = 0;
        other_errs = 0;
        $readmemh("verification/nbody_patterns.txt", pat);
        n_bodies = int'(pat[0][15:0]);
        assert (n_bodies > 0 && n_bodies <= BODIES) else begin
            other_errs++;
            $display("Pattern file gives an unusable body count of %0d", n_bodies);
            n_bodies = 0;
        end
        // GAP of zero still runs one step
        gap_eff = (pat[1][31:0] == '0) ? 64'd1 : {32'd0, pat[1][31:0]};
        for (int i = 0; i < BODIES; i++) begin
            x0[i] = pat[2 + 4 * i];
            y0[i] = pat[3 + 4 * i];
            vx[i] = pat[4 + 4 * i];
            vy[i] = pat[5 + 4 * i];
            steps[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        load_bodies();
        bus_write(N_BODIES, 0, 32'(n_bodies));
        bus_write(GAP, 0, pat[1][31:0]);
        check_positions("load");
        expect_done_low("load done", 1);

        bus_write(READ, 0, 32'd0);
        bus_write(GO, 0, 32'd1);
        wait_done("run1");
        advance(n_bodies);
        check_positions("run1");

        // DONE clears and stays low while READ is held
        bus_write(READ, 0, 32'd1);
        expect_done_low("handshake done", run_window_reads());
        bus_write(READ, 0, 32'd0);
        wait_done("run2");
        advance(n_bodies);
        check_positions("run2");

        bus_write(GO, 0, 32'd0);
        bus_write(READ, 0, 32'd1);
        bus_write(READ, 0, 32'd0);
        expect_done_low("go_low done", run_window_reads());
        check_positions("go_low");

        n_part = n_bodies / 2;
        bus_write(N_BODIES, 0, 32'(n_part));
        bus_write(GO, 0, 32'd1);
        wait_done("partial");
        advance(n_part);
        check_positions("partial");

        bus_read(7'h00, 0, d);
        check_value("unmapped 00h", 64'hffff_ffff, d);
        bus_read(7'h48, 3, d);
        check_value("unmapped 48h", 64'hffff_ffff, d);
        bus_read(DONE, 0, d);
        check_value("done field", 64'd1, d);

        $display("Checks complete: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
